/* hdl/fft_pkg.sv */
package fft_pkg;

  localparam int n_points     = 8;
  localparam int n_stages     = 3;
  localparam int sample_width = 16;
  localparam int frac_bits    = 8;

  localparam real pi = 3.14159265358979323846;

  // One real or imaginary part in Q8.8.
  typedef logic signed [sample_width-1:0] sample_t;

  typedef struct packed {
    sample_t re;
    sample_t im;
  } complex_t;

  typedef logic [1:0] stage_t;

  typedef enum logic [1:0] {
    idle,
    comp,
    done
  } fft_state_e;

  typedef complex_t [n_stages-1:0][n_points/2-1:0] twiddle_tab_t;

  // Entry [s][j] is exp(-i*2*pi*e/8) for butterfly j of pass s.
  // The exponent e keeps only the top s bits of the butterfly index, since the
  // stride permutation brings the low bits of the logical position up there.
  function automatic twiddle_tab_t twiddle_table();
    twiddle_tab_t tab;
    int           mask;
    int           expo;
    real          angle;
    for (int s = 0; s < n_stages; s++) begin
      mask = ((1 << s) - 1) << (n_stages - 1 - s);
      for (int j = 0; j < n_points / 2; j++) begin
        expo  = j & mask;
        angle = 2.0 * pi * expo / n_points;
        tab[s][j].re = sample_t'(int'($cos(angle) * (1 << frac_bits)));
        tab[s][j].im = sample_t'(int'(-$sin(angle) * (1 << frac_bits)));
      end
    end
    return tab;
  endfunction

endpackage

/* hdl/fft_ctrl.sv */
`timescale 1ns/100ps

module fft_ctrl import fft_pkg::*; (
  input  logic clk,
  input  logic reset,
  input  logic recv_val,
  output logic recv_rdy,
  output logic send_val,
  input  logic send_rdy,
  input  logic last,
  output logic load,
  output logic advance
);

  fft_state_e state;
  fft_state_e next_state;

  // In done a new vector may only enter when the sink takes the result.
  assign recv_rdy = (state == idle) || (state == done && send_rdy);
  assign send_val = (state == done);
  assign load     = recv_val && recv_rdy;
  assign advance  = (state == comp);

  always_comb begin
    next_state = state;
    case (state)
      idle: begin
        if (recv_val) begin
          next_state = comp;
        end
      end
      comp: begin
        if (last) begin
          next_state = done;
        end
      end
      done: begin
        if (send_rdy) begin
          next_state = recv_val ? comp : idle;
        end
      end
      default: next_state = idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= next_state;
    end
  end

endmodule

/* hdl/stage_counter.sv */
`timescale 1ns/100ps

module stage_counter import fft_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   advance,
  output stage_t stage,
  output logic   last
);

  assign last = (stage == stage_t'(n_stages - 1));

  // The count wraps on the edge that finishes the final pass.
  always_ff @(posedge clk) begin
    if (reset) begin
      stage <= '0;
    end else if (advance) begin
      if (last) begin
        stage <= '0;
      end else begin
        stage <= stage + 1'b1;
      end
    end
  end

endmodule

/* hdl/twiddle_rom.sv */
`timescale 1ns/100ps

module twiddle_rom import fft_pkg::*; (
  input  stage_t                      stage,
  output complex_t [n_points/2-1:0]   twiddles
);

  twiddle_tab_t tab;

  // The whole table folds to constants, so only the stage select is logic.
  assign tab = twiddle_table();

  always_comb begin
    twiddles = tab[0];
    for (int s = 0; s < n_stages; s++) begin
      if (stage == stage_t'(s)) begin
        twiddles = tab[s];
      end
    end
  end

endmodule

/* hdl/butterfly_array.sv */
`timescale 1ns/100ps

module butterfly_array import fft_pkg::*; (
  input  complex_t [n_points-1:0]   pairs,
  input  complex_t [n_points/2-1:0] twiddles,
  output complex_t [n_points-1:0]   results
);

  for (genvar j = 0; j < n_points / 2; j++) begin : g_bfly
    complex_t                        a;
    complex_t                        b;
    complex_t                        w;
    complex_t                        t;
    logic signed [2*sample_width:0]  prod_re;
    logic signed [2*sample_width:0]  prod_im;
    logic signed [2*sample_width:0]  rnd_re;
    logic signed [2*sample_width:0]  rnd_im;

    assign a = pairs[2*j];
    assign b = pairs[2*j+1];
    assign w = twiddles[j];

    // Full-width complex product, Q16.16 before rounding.
    assign prod_re = b.re * w.re - b.im * w.im;
    assign prod_im = b.re * w.im + b.im * w.re;

    // Round to nearest, then drop the extra fraction bits.
    assign rnd_re = prod_re + (1 << (frac_bits - 1));
    assign rnd_im = prod_im + (1 << (frac_bits - 1));

    assign t.re = rnd_re[frac_bits +: sample_width];
    assign t.im = rnd_im[frac_bits +: sample_width];

    // Sums wrap at the sample width.
    assign results[2*j].re   = a.re + t.re;
    assign results[2*j].im   = a.im + t.im;
    assign results[2*j+1].re = a.re - t.re;
    assign results[2*j+1].im = a.im - t.im;
  end

endmodule

/* hdl/sample_store.sv */
`timescale 1ns/100ps

module sample_store import fft_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      advance,
  input  sample_t  [n_points-1:0]   recv_msg,
  input  complex_t [n_points-1:0]   results,
  output complex_t [n_points-1:0]   pairs
);

  function automatic int bit_reverse(int k);
    int r;
    r = 0;
    for (int b = 0; b < n_stages; b++) begin
      r = (r << 1) | ((k >> b) & 1);
    end
    return r;
  endfunction

  // Inverse perfect shuffle: 2k mod 7 rotates the index left by one bit,
  // which brings the next butterfly partners next to each other.
  function automatic int stride_index(int k);
    if (k == n_points - 1) begin
      return k;
    end
    return (2 * k) % (n_points - 1);
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      pairs <= '0;
    end else if (load) begin
      for (int k = 0; k < n_points; k++) begin
        pairs[k].re <= recv_msg[bit_reverse(k)];
        pairs[k].im <= '0;
      end
    end else if (advance) begin
      for (int k = 0; k < n_points; k++) begin
        pairs[k] <= results[stride_index(k)];
      end
    end
  end

endmodule

/* hdl/fft_pease_top.sv */
`timescale 1ns/100ps

module fft_pease_top import fft_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  sample_t  [n_points-1:0]   recv_msg,
  input  logic                      recv_val,
  output logic                      recv_rdy,
  output complex_t [n_points-1:0]   send_msg,
  output logic                      send_val,
  input  logic                      send_rdy
);

  logic                      load;
  logic                      advance;
  logic                      last;
  stage_t                    stage;
  complex_t [n_points/2-1:0] twiddles;
  complex_t [n_points-1:0]   results;

  fft_ctrl i_fft_ctrl (
    .clk      (clk),
    .reset    (reset),
    .recv_val (recv_val),
    .recv_rdy (recv_rdy),
    .send_val (send_val),
    .send_rdy (send_rdy),
    .last     (last),
    .load     (load),
    .advance  (advance)
  );

  stage_counter i_stage_counter (
    .clk     (clk),
    .reset   (reset),
    .advance (advance),
    .stage   (stage),
    .last    (last)
  );

  twiddle_rom i_twiddle_rom (
    .stage    (stage),
    .twiddles (twiddles)
  );

  // The store contents feed the butterflies and are the transform output.
  butterfly_array i_butterfly_array (
    .pairs    (send_msg),
    .twiddles (twiddles),
    .results  (results)
  );

  sample_store i_sample_store (
    .clk      (clk),
    .reset    (reset),
    .load     (load),
    .advance  (advance),
    .recv_msg (recv_msg),
    .results  (results),
    .pairs    (send_msg)
  );

endmodule

/* tb/fft_asserts.sv */
`timescale 1ns/100ps

module fft_asserts import fft_pkg::*; (
  input logic                    clk,
  input logic                    reset,
  input logic                    recv_val,
  input logic                    recv_rdy,
  input complex_t [n_points-1:0] send_msg,
  input logic                    send_val,
  input logic                    send_rdy
);

  int unsigned fail_count = 0;

  // Reset leaves the engine idle and ready for input.
  reset_idle: assert property (@(posedge clk) reset |=> (!send_val && recv_rdy))
    else begin
      fail_count++;
      $error("Engine is not idle with input ready after reset");
    end

  // Three passes follow each accepted vector, then the result is offered.
  accept_latency: assert property (@(posedge clk) disable iff (reset)
      (recv_val && recv_rdy) |=> !send_val [*3] ##1 send_val)
    else begin
      fail_count++;
      $error("Result valid did not rise four edges after an accepted vector");
    end

  stall_hold: assert property (@(posedge clk) disable iff (reset)
      (send_val && !send_rdy) |=> (send_val && $stable(send_msg)))
    else begin
      fail_count++;
      $error("Result changed or was withdrawn while the sink stalled");
    end

  stall_no_input: assert property (@(posedge clk) disable iff (reset)
      (send_val && !send_rdy) |-> !recv_rdy)
    else begin
      fail_count++;
      $error("Input was ready while the sink stalled");
    end

  // A new vector may only enter in done when the result leaves.
  done_ready: assert property (@(posedge clk) disable iff (reset)
      send_val |-> (recv_rdy == send_rdy))
    else begin
      fail_count++;
      $error("Input ready does not follow sink ready in done");
    end

endmodule

/* tb/fft_tb.sv */
`timescale 1ns/100ps

module fft_tb import fft_pkg::*; ();

  typedef sample_t [n_points-1:0] vector_t;

  localparam int  n_vectors      = 40;
  localparam real tolerance      = 0.1;
  localparam real clk_period     = 100.0;
  localparam int  reset_cycles   = 16;
  localparam int  timeout_cycles = n_vectors * 12 + 100;

  logic                    clk;
  logic                    reset;
  vector_t                 recv_msg;
  logic                    recv_val;
  logic                    recv_rdy;
  complex_t [n_points-1:0] send_msg;
  logic                    send_val;
  logic                    send_rdy;

  logic [31:0] lfsr_state;
  real         expect_re[$];
  real         expect_im[$];
  int          sent_count   = 0;
  int          recv_count   = 0;
  int          bin_errors   = 0;
  int          order_errors = 0;

  fft_pease_top i_fft_pease_top (.*);

  bind fft_pease_top fft_asserts i_fft_asserts (.*);

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out) begin
      lfsr_state = lfsr_state ^ 32'h80200003;
    end
    return out;
  endfunction

  function automatic int random_bits(int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      value = (value << 1) | lfsr_bit();
    end
    return value;
  endfunction

  function automatic real to_real(sample_t v);
    return real'(v) / real'(1 << frac_bits);
  endfunction

  function automatic real abs_diff(real a, real b);
    return (a > b) ? (a - b) : (b - a);
  endfunction

  // Vector 0 is an impulse, vector 1 a constant 1.0, the rest random within +-8.0.
  function automatic vector_t make_vector(int index);
    vector_t            v;
    logic signed [11:0] raw;
    for (int n = 0; n < n_points; n++) begin
      if (index == 0) begin
        v[n] = (n == 0) ? sample_t'(1 << frac_bits) : sample_t'(0);
      end else if (index == 1) begin
        v[n] = sample_t'(1 << frac_bits);
      end else begin
        raw  = random_bits(12);
        v[n] = sample_t'(raw);
      end
    end
    return v;
  endfunction

  task automatic push_model(input vector_t x);
    real acc_re;
    real acc_im;
    real angle;
    for (int k = 0; k < n_points; k++) begin
      acc_re = 0.0;
      acc_im = 0.0;
      for (int n = 0; n < n_points; n++) begin
        angle  = 2.0 * pi * k * n / n_points;
        acc_re = acc_re + to_real(x[n]) * $cos(angle);
        acc_im = acc_im - to_real(x[n]) * $sin(angle);
      end
      expect_re.push_back(acc_re);
      expect_im.push_back(acc_im);
    end
  endtask

  task automatic check_bin(input int k, input complex_t got, input real exp_re,
                           input real exp_im, input real limit);
    real got_re;
    real got_im;
    got_re = to_real(got.re);
    got_im = to_real(got.im);
    assert (abs_diff(got_re, exp_re) <= limit) else begin
      bin_errors++;
      $display("FAILED at %0t: send_msg[%0d].re = %f, expected %f", $time, k, got_re, exp_re);
    end
    assert (abs_diff(got_im, exp_im) <= limit) else begin
      bin_errors++;
      $display("FAILED at %0t: send_msg[%0d].im = %f, expected %f", $time, k, got_im, exp_im);
    end
  endtask

  function automatic int total_errors();
    return bin_errors + order_errors + i_fft_pease_top.i_fft_asserts.fail_count;
  endfunction

  task automatic report_counts();
    $display("Vectors sent %0d, received %0d; bin mismatches %0d, order errors %0d, %0s %0d",
             sent_count, recv_count, bin_errors, order_errors, "assertion failures",
             i_fft_pease_top.i_fft_asserts.fail_count);
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #(clk_period / 2.0) clk = ~clk;
  end

  // Outputs are checked before the vector accepted on the same edge is modelled.
  always @(posedge clk) begin
    if (!reset && send_val && send_rdy) begin
      recv_count++;
      assert (expect_re.size() >= n_points) else begin
        order_errors++;
        $display("Output transfer at %0t arrived with no vector outstanding", $time);
      end
      if (expect_re.size() >= n_points) begin
        // The impulse in the first vector has to come out exact.
        for (int k = 0; k < n_points; k++) begin
          check_bin(k, send_msg[k], expect_re.pop_front(), expect_im.pop_front(),
                    (recv_count == 1) ? 0.0 : tolerance);
        end
      end
    end
    if (!reset && recv_val && recv_rdy) begin
      sent_count++;
      push_model(recv_msg);
    end
  end

  initial begin : watchdog
    #(clk_period * timeout_cycles);
    $display("Timeout after %0d clock periods with %0d of %0d results received",
             timeout_cycles, recv_count, n_vectors);
    report_counts();
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    int stall_left;
    int offered;
    lfsr_state = 32'h78f1a552;
    reset      = 1'b1;
    recv_val   = 1'b0;
    recv_msg   = '0;
    send_rdy   = 1'b0;
    stall_left = 0;
    offered    = -1;
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    while (recv_count < n_vectors) begin
      @(negedge clk);
      if (sent_count >= n_vectors) begin
        recv_val = 1'b0;
      end else begin
        if (offered != sent_count) begin
          recv_msg = make_vector(sent_count);
          offered  = sent_count;
          recv_val = 1'b0;
        end
        // The second half keeps valid high so vectors follow back to back.
        if (!recv_val) begin
          recv_val = (sent_count >= n_vectors / 2) || lfsr_bit();
        end
      end
      if (stall_left > 0) begin
        stall_left--;
        send_rdy = 1'b0;
      end else if (sent_count >= 2 && random_bits(2) == 0) begin
        stall_left = random_bits(2);
        send_rdy   = 1'b0;
      end else begin
        send_rdy = 1'b1;
      end
    end
    repeat (4) @(negedge clk);
    assert (expect_re.size() == 0) else begin
      order_errors++;
      $display("Model still holds %0d bins after the last output", expect_re.size());
    end
    report_counts();
    if (total_errors() == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/fft_pkg.sv
hdl/fft_ctrl.sv
hdl/stage_counter.sv
hdl/twiddle_rom.sv
hdl/butterfly_array.sv
hdl/sample_store.sv
hdl/fft_pease_top.sv
tb/fft_asserts.sv
tb/fft_tb.sv
